// File: printerPkg.sv
package printerPkg;

    // ----------------------------------------------------------------------
    // Word widths
    // ----------------------------------------------------------------------

    // Command word from the outside world
    localparam int CmdWidth     = 32;
    // Bit 16 is the RS level (1 data, 0 command), bits 15..0 the bus value
    localparam int LcdWordWidth = 17;
    // Value field of a command and LCD bus width
    localparam int ValueWidth   = 16;

    // ----------------------------------------------------------------------
    // Command field positions
    // ----------------------------------------------------------------------

    localparam int OpcodeMsb = 31;
    localparam int OpcodeLsb = 30;
    // Fill repeat count, 14 bits
    localparam int CountMsb  = 29;
    localparam int CountLsb  = 16;

    // Command opcodes
    typedef enum logic [1:0] {
        OpCmd  = 2'd0,
        OpData = 2'd1,
        OpFill = 2'd2,
        OpNop  = 2'd3
    } printerOp_t;

    // Printer engine FSM
    typedef enum logic [1:0] {
        EngIdle,
        Fetch,
        Emit
    } engineState_t;

    // LCD write cycle FSM
    typedef enum logic [1:0] {
        WrIdle,
        WrLow,
        WrHigh
    } writerState_t;

endpackage

// File: syncFifo.sv
`timescale 1ns/1ps

module syncFifo #(
    parameter int Width     = 32,
    parameter int DepthLog2 = 2
) (
    input  logic             clk,
    input  logic             RSTn,
    input  logic             push,
    input  logic [Width-1:0] wdata,
    input  logic             pop,
    output logic [Width-1:0] rdata,
    output logic             full,
    output logic             empty
);

    localparam int Depth = 1 << DepthLog2;

    logic [Width-1:0]   mem [Depth];
    // One extra bit tells a full FIFO from an empty one
    logic [DepthLog2:0] wrPtr;
    logic [DepthLog2:0] rdPtr;
    logic               doPush;
    logic               doPop;

    assign doPush = push && !full;
    assign doPop  = pop && !empty;

    // ----------------------------------------------------------------------
    // Flags from the pointer pair
    // ----------------------------------------------------------------------

    assign empty = (wrPtr == rdPtr);
    assign full  = (wrPtr[DepthLog2] != rdPtr[DepthLog2]) &&
                   (wrPtr[DepthLog2-1:0] == rdPtr[DepthLog2-1:0]);

    // Head word shown without a read latency
    assign rdata = mem[rdPtr[DepthLog2-1:0]];

    // ----------------------------------------------------------------------
    // Storage and pointers
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr[DepthLog2-1:0]] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

endmodule

// File: printerEngine.sv
`timescale 1ns/1ps

module printerEngine (
    input  logic                                clk,
    input  logic                                RSTn,
    input  logic                                cmdEmpty,
    input  logic [printerPkg::CmdWidth-1:0]     cmdRdata,
    input  logic                                dispFull,
    output logic                                cmdPop,
    output logic                                dispPush,
    output logic [printerPkg::LcdWordWidth-1:0] dispWdata
);

    import printerPkg::*;

    localparam int CountWidth = CountMsb - CountLsb + 1;

    engineState_t          state;
    printerOp_t            opcode;
    logic [CountWidth-1:0] cmdCount;
    // Words still to emit for the current command
    logic [CountWidth-1:0] remaining;
    logic                  rsLevel;
    logic [ValueWidth-1:0] value;

    // ----------------------------------------------------------------------
    // Command decode
    // ----------------------------------------------------------------------

    assign opcode   = printerOp_t'(cmdRdata[OpcodeMsb:OpcodeLsb]);
    assign cmdCount = cmdRdata[CountMsb:CountLsb];

    // Pop and latch happen together in Fetch
    assign cmdPop    = (state == Fetch);
    // Back-pressure from the display FIFO
    assign dispPush  = (state == Emit) && !dispFull;
    assign dispWdata = {rsLevel, value};

    // Payload of the current command
    always_ff @(posedge clk) begin
        if (cmdPop) begin
            rsLevel <= (opcode != OpCmd);
            value   <= cmdRdata[ValueWidth-1:0];
        end
    end

    // ----------------------------------------------------------------------
    // Expansion FSM
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            state     <= EngIdle;
            remaining <= '0;
        end else begin
            case (state)
                EngIdle: begin
                    if (!cmdEmpty) begin
                        state <= Fetch;
                    end
                end
                Fetch: begin
                    case (opcode)
                        OpCmd, OpData: begin
                            remaining <= CountWidth'(1);
                            state     <= Emit;
                        end
                        OpFill: begin
                            remaining <= cmdCount;
                            // Zero-count fill is consumed silently
                            state     <= (cmdCount == '0) ? EngIdle : Emit;
                        end
                        default: begin
                            state <= EngIdle;
                        end
                    endcase
                end
                Emit: begin
                    if (dispPush) begin
                        remaining <= remaining - 1'b1;
                        if (remaining == CountWidth'(1)) begin
                            state <= EngIdle;
                        end
                    end
                end
                default: begin
                    state <= EngIdle;
                end
            endcase
        end
    end

endmodule

// File: lcdWriter.sv
`timescale 1ns/1ps

module lcdWriter #(
    parameter int WrLowCycles  = 3,
    parameter int WrHighCycles = 2
) (
    input  logic                                clk,
    input  logic                                RSTn,
    input  logic                                dispEmpty,
    input  logic [printerPkg::LcdWordWidth-1:0] dispRdata,
    output logic                                dispPop,
    output logic                                LCD_CS,
    output logic                                LCD_RS,
    output logic                                LCD_WR,
    output logic [printerPkg::ValueWidth-1:0]   LCD_DATA
);

    import printerPkg::*;

    localparam int MaxCycles = (WrLowCycles > WrHighCycles) ? WrLowCycles : WrHighCycles;
    localparam int CntWidth  = $clog2(MaxCycles + 1);

    writerState_t        state;
    // Cycles left in the current WR phase, minus one
    logic [CntWidth-1:0] phaseCnt;
    logic                phaseDone;

    assign phaseDone = (phaseCnt == '0);

    // New word taken from Idle, or back to back at the end of the high phase
    assign dispPop = !dispEmpty &&
                     ((state == WrIdle) || ((state == WrHigh) && phaseDone));

    // ----------------------------------------------------------------------
    // Bus value and RS, held for the whole write
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            LCD_RS   <= 1'b0;
            LCD_DATA <= '0;
        end else if (dispPop) begin
            LCD_RS   <= dispRdata[ValueWidth];
            LCD_DATA <= dispRdata[ValueWidth-1:0];
        end
    end

    // ----------------------------------------------------------------------
    // 8080 write cycle FSM
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            state    <= WrIdle;
            phaseCnt <= '0;
            LCD_CS   <= 1'b1;
            LCD_WR   <= 1'b1;
        end else begin
            case (state)
                WrIdle, WrHigh: begin
                    if (state == WrIdle || phaseDone) begin
                        if (dispPop) begin
                            state    <= WrLow;
                            phaseCnt <= CntWidth'(WrLowCycles - 1);
                            LCD_CS   <= 1'b0;
                            LCD_WR   <= 1'b0;
                        end else begin
                            state  <= WrIdle;
                            LCD_CS <= 1'b1;
                        end
                    end else begin
                        phaseCnt <= phaseCnt - 1'b1;
                    end
                end
                WrLow: begin
                    if (phaseDone) begin
                        // Rising WR edge latches the word in the LCD
                        state    <= WrHigh;
                        phaseCnt <= CntWidth'(WrHighCycles - 1);
                        LCD_WR   <= 1'b1;
                    end else begin
                        phaseCnt <= phaseCnt - 1'b1;
                    end
                end
                default: begin
                    state <= WrIdle;
                end
            endcase
        end
    end

endmodule

// File: printerTop.sv
`timescale 1ns/1ps

module printerTop #(
    parameter int CmdDepthLog2  = 2,
    parameter int DispDepthLog2 = 2,
    parameter int WrLowCycles   = 3,
    parameter int WrHighCycles  = 2
) (
    input  logic                              clk,
    input  logic                              RSTn,
    input  logic                              cmdWrite,
    input  logic [printerPkg::CmdWidth-1:0]   cmdData,
    output logic                              cmdFull,
    output logic                              LCD_CS,
    output logic                              LCD_RS,
    output logic                              LCD_WR,
    output logic [printerPkg::ValueWidth-1:0] LCD_DATA
);

    import printerPkg::*;

    // ----------------------------------------------------------------------
    // Command path
    // ----------------------------------------------------------------------

    logic                cmdEmpty;
    logic                cmdPop;
    logic [CmdWidth-1:0] cmdRdata;

    syncFifo #(
        .Width     (CmdWidth),
        .DepthLog2 (CmdDepthLog2)
    ) cmdFifo (
        .clk   (clk),
        .RSTn  (RSTn),
        .push  (cmdWrite),
        .wdata (cmdData),
        .pop   (cmdPop),
        .rdata (cmdRdata),
        .full  (cmdFull),
        .empty (cmdEmpty)
    );

    // ----------------------------------------------------------------------
    // Expansion into display words
    // ----------------------------------------------------------------------

    logic                    dispPush;
    logic                    dispFull;
    logic [LcdWordWidth-1:0] dispWdata;

    printerEngine engine (
        .clk       (clk),
        .RSTn      (RSTn),
        .cmdEmpty  (cmdEmpty),
        .cmdRdata  (cmdRdata),
        .dispFull  (dispFull),
        .cmdPop    (cmdPop),
        .dispPush  (dispPush),
        .dispWdata (dispWdata)
    );

    // ----------------------------------------------------------------------
    // Display word buffer and LCD bus
    // ----------------------------------------------------------------------

    logic                    dispEmpty;
    logic                    dispPop;
    logic [LcdWordWidth-1:0] dispRdata;

    syncFifo #(
        .Width     (LcdWordWidth),
        .DepthLog2 (DispDepthLog2)
    ) dispFifo (
        .clk   (clk),
        .RSTn  (RSTn),
        .push  (dispPush),
        .wdata (dispWdata),
        .pop   (dispPop),
        .rdata (dispRdata),
        .full  (dispFull),
        .empty (dispEmpty)
    );

    lcdWriter #(
        .WrLowCycles  (WrLowCycles),
        .WrHighCycles (WrHighCycles)
    ) writer (
        .clk       (clk),
        .RSTn      (RSTn),
        .dispEmpty (dispEmpty),
        .dispRdata (dispRdata),
        .dispPop   (dispPop),
        .LCD_CS    (LCD_CS),
        .LCD_RS    (LCD_RS),
        .LCD_WR    (LCD_WR),
        .LCD_DATA  (LCD_DATA)
    );

endmodule

// File: tbPrinterTop.sv
`timescale 1ns/1ps

module tbPrinterTop;

    import printerPkg::*;

    localparam int WrLow     = 3;
    localparam int WrHigh    = 2;
    localparam int WaitLimit = 20000;

    logic                  clk;
    logic                  RSTn;
    logic                  cmdWrite;
    logic [CmdWidth-1:0]   cmdData;
    logic                  cmdFull;
    logic                  LCD_CS;
    logic                  LCD_RS;
    logic                  LCD_WR;
    logic [ValueWidth-1:0] LCD_DATA;

    // Words the LCD should latch in order
    logic [LcdWordWidth-1:0] expQ [$];
    logic [LcdWordWidth-1:0] expWord;
    int                      expTotal = 0;
    int                      wrCount  = 0;
    logic [31:0]             lcgState = 32'd43411;

    // Bus monitor state
    logic                  prevWr   = 1'b1;
    int                    lowCnt   = 0;
    int                    highCnt  = WrHigh;
    logic                  heldRs   = 1'b0;
    logic [ValueWidth-1:0] heldData = '0;

    printerTop #(
        .CmdDepthLog2  (2),
        .DispDepthLog2 (2),
        .WrLowCycles   (WrLow),
        .WrHighCycles  (WrHigh)
    ) UUT (
        .clk      (clk),
        .RSTn     (RSTn),
        .cmdWrite (cmdWrite),
        .cmdData  (cmdData),
        .cmdFull  (cmdFull),
        .LCD_CS   (LCD_CS),
        .LCD_RS   (LCD_RS),
        .LCD_WR   (LCD_WR),
        .LCD_DATA (LCD_DATA)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [CmdWidth-1:0] makeCmd(input printerOp_t op, input int count,
                                                    input logic [ValueWidth-1:0] value);
        logic [CmdWidth-1:0] cmd;
        cmd                      = '0;
        cmd[OpcodeMsb:OpcodeLsb] = op;
        cmd[CountMsb:CountLsb]   = count[13:0];
        cmd[ValueWidth-1:0]      = value;
        return cmd;
    endfunction

    // Reference model of the command expansion
    function automatic void expandCmd(input logic [CmdWidth-1:0] cmd);
        printerOp_t op;
        int         count;
        op    = printerOp_t'(cmd[OpcodeMsb:OpcodeLsb]);
        count = int'(cmd[CountMsb:CountLsb]);
        case (op)
            OpCmd: begin
                expQ.push_back({1'b0, cmd[ValueWidth-1:0]});
                expTotal++;
            end
            OpData: begin
                expQ.push_back({1'b1, cmd[ValueWidth-1:0]});
                expTotal++;
            end
            OpFill: begin
                for (int i = 0; i < count; i++) begin
                    expQ.push_back({1'b1, cmd[ValueWidth-1:0]});
                    expTotal++;
                end
            end
            default: begin
            end
        endcase
    endfunction

    task automatic abortRun();
        $display("SIMULATION FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: expected 0x%0h, got 0x%0h", name, exp, got);
            abortRun();
        end
    endtask

    task automatic checkTrue(input logic cond, input string what);
        assert (cond) else begin
            $display("ERROR: %s", what);
            abortRun();
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("TIMEOUT: %s", what);
        abortRun();
    endtask

    // Called on a rising clock edge and returns one edge later
    task automatic pushCmd(input logic [CmdWidth-1:0] cmd);
        cmdWrite <= 1'b1;
        cmdData  <= cmd;
        expandCmd(cmd);
        @(posedge clk);
        cmdWrite <= 1'b0;
    endtask

    task automatic sendCmd(input logic [CmdWidth-1:0] cmd);
        int waited;
        waited = 0;
        @(posedge clk);
        while (cmdFull) begin
            if (waited >= WaitLimit) begin
                reportTimeout("cmdFull stayed high, command FIFO never drained");
            end else begin
                waited++;
                @(posedge clk);
            end
        end
        pushCmd(cmd);
    endtask

    task automatic waitDrain(input string phase);
        int waited;
        waited = 0;
        @(posedge clk);
        while (wrCount != expTotal) begin
            if (waited >= WaitLimit) begin
                reportTimeout({"LCD writes did not complete after ", phase});
            end else begin
                waited++;
                @(posedge clk);
            end
        end
        // Chip select goes high once the last high phase ends
        waited = 0;
        while (!LCD_CS && waited < WrHigh) begin
            waited++;
            @(posedge clk);
        end
        checkValue("cmdFull", 32'(cmdFull), 32'd0);
        checkValue("LCD_CS", 32'(LCD_CS), 32'd1);
    endtask

    // ----------------------------------------------------------------------
    // LCD bus monitor sampled on the clock
    // ----------------------------------------------------------------------

    always @(posedge clk) begin
        if (!RSTn) begin
            prevWr  = 1'b1;
            lowCnt  = 0;
            highCnt = WrHigh;
        end else begin
            if (!LCD_WR) begin
                checkTrue(!LCD_CS, "LCD_CS high while LCD_WR is low");
                if (prevWr) begin
                    checkTrue(highCnt >= WrHigh, "LCD_WR high phase shorter than 2 cycles");
                    lowCnt = 1;
                end else begin
                    // Bus must hold still during the low phase
                    checkValue("LCD_RS", 32'(LCD_RS), 32'(heldRs));
                    checkValue("LCD_DATA", 32'(LCD_DATA), 32'(heldData));
                    lowCnt = lowCnt + 1;
                end
                heldRs   = LCD_RS;
                heldData = LCD_DATA;
            end else if (!prevWr) begin
                // WR just rose so the LCD latched this word
                checkValue("LCD_WR low cycles", lowCnt, WrLow);
                checkTrue(expQ.size() > 0, "LCD write seen with no word expected");
                expWord = expQ.pop_front();
                checkValue("LCD_RS", 32'(LCD_RS), 32'(expWord[ValueWidth]));
                checkValue("LCD_DATA", 32'(LCD_DATA), 32'(expWord[ValueWidth-1:0]));
                wrCount <= wrCount + 1;
                highCnt = 1;
            end else begin
                highCnt = highCnt + 1;
            end
            prevWr = LCD_WR;
        end
    end

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------

    initial begin
        int   accepted;
        logic sawFull;
        RSTn     <= 1'b0;
        cmdWrite <= 1'b0;
        cmdData  <= '0;
        repeat (5) @(posedge clk);
        RSTn <= 1'b1;

        @(posedge clk);
        checkValue("LCD_CS", 32'(LCD_CS), 32'd1);
        checkValue("LCD_WR", 32'(LCD_WR), 32'd1);
        checkValue("LCD_RS", 32'(LCD_RS), 32'd0);
        checkValue("LCD_DATA", 32'(LCD_DATA), 32'd0);
        checkValue("cmdFull", 32'(cmdFull), 32'd0);
        repeat (10) @(posedge clk);
        checkValue("write count before first command", wrCount, 0);

        // Single command and data words
        for (int i = 0; i < 40; i++) begin
            sendCmd(makeCmd(nextRand() & 32'h0001_0000 ? OpData : OpCmd,
                            int'(nextRand() >> 18), 16'(nextRand() >> 16)));
        end
        waitDrain("single words");

        // Commands that emit nothing and then a random mix
        sendCmd(makeCmd(OpNop, 5, 16'h1234));
        sendCmd(makeCmd(OpFill, 0, 16'hbeef));
        for (int i = 0; i < 40; i++) begin
            sendCmd(makeCmd(printerOp_t'(nextRand() >> 30), int'((nextRand() >> 16) % 41),
                            16'(nextRand() >> 16)));
        end
        waitDrain("fills and skipped commands");

        // Long fill stalls the engine so the command FIFO fills up
        sendCmd(makeCmd(OpFill, 300, 16'(nextRand() >> 16)));
        accepted = 1;
        sawFull  = 1'b0;
        while (!sawFull) begin
            @(posedge clk);
            if (cmdFull) begin
                sawFull = 1'b1;
            end else begin
                checkTrue(accepted < 6, "cmdFull did not rise after 6 accepted commands");
                pushCmd(makeCmd(OpData, 0, 16'(nextRand() >> 16)));
                accepted++;
            end
        end
        waitDrain("back-pressure");

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: sim.f
printerPkg.sv
syncFifo.sv
printerEngine.sv
lcdWriter.sv
printerTop.sv
tbPrinterTop.sv

// File: Makefile
# Verilator build for the printer path testbench

VERILATOR ?= verilator
TOP_TB    ?= tbPrinterTop
TOP_RTL   ?= printerTop
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall
RTL_SRCS  ?= printerPkg.sv syncFifo.sv printerEngine.sv lcdWriter.sv printerTop.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP_TB) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP_TB)

run: build
	./$(BUILD_DIR)/V$(TOP_TB)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP_RTL) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
